// ==== rtl/gcdController.sv ====
//----------------------------------------
// GCD engine controller
// Load, reduce and issue sequencing with
// result credit counting
//----------------------------------------

`timescale 1ns/1ps

module gcdController import gcdPkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     notEmpty,
	output logic     pop,
	input  logic     resCredit,
	output logic     resValid,
	gcdCtrlIf.ctrl   ctl
);

	gcdState state;
	gcdState nextState;

	// Result credits still held by the engine
	logic [CREDIT_W-1:0] resCnt;
	logic issue;
	logic haveCredit;

	assign haveCredit = (resCnt != '0);

	// State register
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	// Next state and datapath controls
	always_comb begin
		nextState = state;
		pop = 1'b0;
		issue = 1'b0;
		ctl.ldP = 1'b0;
		ctl.ldQ = 1'b0;
		ctl.ldG = 1'b0;
		ctl.selInit = 1'b0;
		ctl.subPQ = 1'b0;

		case (state)
			IDLE: begin
				// Take the head job and load both operands
				if (notEmpty) begin
					pop = 1'b1;
					ctl.selInit = 1'b1;
					ctl.ldP = 1'b1;
					ctl.ldQ = 1'b1;
					nextState = REDUCE;
				end
			end

			REDUCE: begin
				if (ctl.pEqQ || ctl.anyZero) begin
					// Done, P OR Q holds the GCD
					ctl.ldG = 1'b1;
					nextState = ISSUE;
				end else if (ctl.pLtQ) begin
					// Q takes Q - P
					ctl.ldQ = 1'b1;
				end else begin
					// P takes P - Q
					ctl.ldP = 1'b1;
					ctl.subPQ = 1'b1;
				end
			end

			ISSUE: begin
				// Hold the result until the consumer has room
				if (haveCredit) begin
					issue = 1'b1;
					nextState = IDLE;
				end
			end

			default: begin
				nextState = IDLE;
			end
		endcase
	end

	// Credit returns and issues can land in the same cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			resCnt <= CREDIT_W'(RES_CREDITS);
		end else begin
			resCnt <= resCnt + CREDIT_W'(resCredit) - CREDIT_W'(issue);
		end
	end

	// Registered result strobe, one cycle per issue
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			resValid <= 1'b0;
		end else begin
			resValid <= issue;
		end
	end

endmodule

// ==== rtl/gcdCtrlIf.sv ====
//----------------------------------------
// GCD engine control bus
// Loads and selects from the controller,
// compare flags from the datapath
//----------------------------------------

`timescale 1ns/1ps

interface gcdCtrlIf;

	// Register loads and mux selects
	logic ldP;
	logic ldQ;
	logic ldG;
	logic selInit;
	logic subPQ;

	// Compare flags from the operand registers
	logic pEqQ;
	logic pLtQ;
	logic anyZero;

	modport ctrl (
		output ldP, ldQ, ldG, selInit, subPQ,
		input  pEqQ, pLtQ, anyZero
	);

	modport dp (
		input  ldP, ldQ, ldG, selInit, subPQ,
		output pEqQ, pLtQ, anyZero
	);

endinterface

// ==== rtl/gcdDatapath.sv ====
//----------------------------------------
// GCD engine datapath
// Operand registers, subtractor, compare
// and the result and tag registers
//----------------------------------------

`timescale 1ns/1ps

module gcdDatapath import gcdPkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  logic [GCD_W-1:0] headA,
	input  logic [GCD_W-1:0] headB,
	input  logic [TAG_W-1:0] headTag,
	gcdCtrlIf.dp             ctl,
	output logic [GCD_W-1:0] resGcd,
	output logic [TAG_W-1:0] resTag
);

	logic [GCD_W-1:0] regP;
	logic [GCD_W-1:0] regQ;
	logic [TAG_W-1:0] jobTag;
	logic [GCD_W-1:0] diff;

	// Shared subtractor, direction picked by the controller
	assign diff = ctl.subPQ ? (regP - regQ) : (regQ - regP);

	// Compare flags
	assign ctl.pEqQ = (regP == regQ);
	assign ctl.pLtQ = (regP < regQ);
	assign ctl.anyZero = (regP == '0) || (regQ == '0);

	// P with its initial load mux
	always_ff @(posedge clk) begin
		if (ctl.ldP) begin
			regP <= ctl.selInit ? headA : diff;
		end
	end

	// Q with its initial load mux
	always_ff @(posedge clk) begin
		if (ctl.ldQ) begin
			regQ <= ctl.selInit ? headB : diff;
		end
	end

	// Tag follows the job from the initial load
	always_ff @(posedge clk) begin
		if (ctl.selInit) begin
			jobTag <= headTag;
		end
	end

	// Result register, P OR Q also covers a zero operand
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			resGcd <= '0;
			resTag <= '0;
		end else if (ctl.ldG) begin
			resGcd <= regP | regQ;
			resTag <= jobTag;
		end
	end

endmodule

// ==== rtl/gcdPkg.sv ====
//----------------------------------------
// GCD coprocessor package
// Sizes, credit counts and engine states
//----------------------------------------

package gcdPkg;

	// Operand, result and tag widths
	localparam int GCD_W = 32;
	localparam int TAG_W = 4;

	// Job queue size, equal to the producer's request credits
	localparam int QUEUE_DEPTH = 4;
	localparam int QPTR_W = $clog2(QUEUE_DEPTH);
	localparam int QCNT_W = QPTR_W + 1;

	// Result credits held by the engine after reset
	localparam int RES_CREDITS = 2;
	localparam int CREDIT_W = 3;

	// Engine states
	typedef enum logic [1:0] {
		IDLE,
		REDUCE,
		ISSUE
	} gcdState;

endpackage

// ==== rtl/gcdTop.sv ====
//----------------------------------------
// GCD coprocessor top level
// Job queue, controller and datapath
//----------------------------------------

`timescale 1ns/1ps

module gcdTop import gcdPkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  logic             reqValid,
	input  logic [GCD_W-1:0] reqA,
	input  logic [GCD_W-1:0] reqB,
	input  logic [TAG_W-1:0] reqTag,
	output logic             reqCredit,
	output logic             resValid,
	output logic [GCD_W-1:0] resGcd,
	output logic [TAG_W-1:0] resTag,
	input  logic             resCredit
);

	// Queue to controller and datapath
	logic             notEmpty;
	logic             pop;
	logic [GCD_W-1:0] headA;
	logic [GCD_W-1:0] headB;
	logic [TAG_W-1:0] headTag;

	gcdCtrlIf ctlBus ();

	jobQueue u_jobQueue (
		.clk       (clk),
		.reset     (reset),
		.reqValid  (reqValid),
		.reqA      (reqA),
		.reqB      (reqB),
		.reqTag    (reqTag),
		.pop       (pop),
		.notEmpty  (notEmpty),
		.headA     (headA),
		.headB     (headB),
		.headTag   (headTag),
		.reqCredit (reqCredit)
	);

	gcdController u_gcdController (
		.clk       (clk),
		.reset     (reset),
		.notEmpty  (notEmpty),
		.pop       (pop),
		.resCredit (resCredit),
		.resValid  (resValid),
		.ctl       (ctlBus.ctrl)
	);

	gcdDatapath u_gcdDatapath (
		.clk     (clk),
		.reset   (reset),
		.headA   (headA),
		.headB   (headB),
		.headTag (headTag),
		.ctl     (ctlBus.dp),
		.resGcd  (resGcd),
		.resTag  (resTag)
	);

endmodule

// ==== rtl/jobQueue.sv ====
//----------------------------------------
// GCD job queue
// Show-ahead FIFO of jobs, one request
// credit returned per popped entry
//----------------------------------------

`timescale 1ns/1ps

module jobQueue import gcdPkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  logic             reqValid,
	input  logic [GCD_W-1:0] reqA,
	input  logic [GCD_W-1:0] reqB,
	input  logic [TAG_W-1:0] reqTag,
	input  logic             pop,
	output logic             notEmpty,
	output logic [GCD_W-1:0] headA,
	output logic [GCD_W-1:0] headB,
	output logic [TAG_W-1:0] headTag,
	output logic             reqCredit
);

	// Job storage
	logic [GCD_W-1:0] memA [QUEUE_DEPTH];
	logic [GCD_W-1:0] memB [QUEUE_DEPTH];
	logic [TAG_W-1:0] memTag [QUEUE_DEPTH];

	logic [QPTR_W-1:0] wrPtr;
	logic [QPTR_W-1:0] rdPtr;
	logic [QCNT_W-1:0] count;

	logic doPush;
	logic doPop;

	// The credit rule keeps the queue from overflowing,
	// the full check is only a guard
	assign doPush = reqValid && (count != QCNT_W'(QUEUE_DEPTH));
	assign doPop = pop && notEmpty;

	assign notEmpty = (count != '0);

	// Head entry read straight out of storage
	assign headA = memA[rdPtr];
	assign headB = memB[rdPtr];
	assign headTag = memTag[rdPtr];

	always_ff @(posedge clk) begin
		if (doPush) begin
			memA[wrPtr] <= reqA;
			memB[wrPtr] <= reqB;
			memTag[wrPtr] <= reqTag;
		end
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
		end
	end

	// Occupancy, push and pop may share a cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
		end else begin
			count <= count + QCNT_W'(doPush) - QCNT_W'(doPop);
		end
	end

	// One credit pulse in the cycle after each pop edge
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			reqCredit <= 1'b0;
		end else begin
			reqCredit <= doPop;
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the GCD coprocessor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f src.f --top-module gcdTb \
	-Mdir obj_dir -o gcdSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/gcdSim > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
	echo "Test failed"
	exit 1
fi
if [ $runStatus -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi
echo "Test passed"
exit 0

// ==== src.f ====
rtl/gcdPkg.sv
rtl/gcdCtrlIf.sv
rtl/jobQueue.sv
rtl/gcdController.sv
rtl/gcdDatapath.sv
rtl/gcdTop.sv
testbench/gcdTb.sv

// ==== testbench/gcdTb.sv ====
//----------------------------------------
// GCD coprocessor testbench
// Random jobs under credit rules, checked
// against a Euclidean model
//----------------------------------------

`timescale 1ns/1ps

module gcdTb import gcdPkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int NUM_JOBS = 300;
	localparam int HOLD_AT_JOB = 120;
	localparam int HOLD_CYCLES = 500;
	// Worst reduction is about 4095 subtractions per job
	localparam longint WATCHDOG_NS = longint'(NUM_JOBS) * 4200 * CLK_PERIOD
		+ longint'(HOLD_CYCLES) * CLK_PERIOD + 20000;

	logic             clk;
	logic             reset;
	logic             reqValid;
	logic [GCD_W-1:0] reqA;
	logic [GCD_W-1:0] reqB;
	logic [TAG_W-1:0] reqTag;
	logic             reqCredit;
	logic             resValid;
	logic [GCD_W-1:0] resGcd;
	logic [TAG_W-1:0] resTag;
	logic             resCredit;

	// Expected results in send order
	logic [GCD_W-1:0] expGcd [$];
	logic [TAG_W-1:0] expTag [$];

	logic [31:0]      rngState = 32'd52024;
	logic [TAG_W-1:0] nextTag;
	int sent;
	int received;
	int creditPulses;
	int granted;
	int holdLeft;
	bit holdDone;
	bit firstCycleSeen;

	gcdTop u_gcdTop (
		.clk       (clk),
		.reset     (reset),
		.reqValid  (reqValid),
		.reqA      (reqA),
		.reqB      (reqB),
		.reqTag    (reqTag),
		.reqCredit (reqCredit),
		.resValid  (resValid),
		.resGcd    (resGcd),
		.resTag    (resTag),
		.resCredit (resCredit)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stopOnFailure();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
			stopOnFailure();
		end
	endtask

	// xorshift32
	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// Euclid by remainder
	function automatic logic [GCD_W-1:0] modelGcd(input logic [GCD_W-1:0] x,
		input logic [GCD_W-1:0] y);
		logic [GCD_W-1:0] a;
		logic [GCD_W-1:0] b;
		logic [GCD_W-1:0] t;
		a = x;
		b = y;
		while (b != '0) begin
			t = a % b;
			a = b;
			b = t;
		end
		return a;
	endfunction

	task automatic makeOperands(output logic [GCD_W-1:0] a, output logic [GCD_W-1:0] b);
		logic [31:0] r;
		int kind;
		a = (nextRandom() % 4095) + 1;
		b = (nextRandom() % 4095) + 1;
		r = nextRandom();
		// Roughly one job in eight has a zero operand
		if (r[2:0] == 3'd0) begin
			kind = int'(nextRandom() % 3);
			if (kind == 0) begin
				a = '0;
			end else if (kind == 1) begin
				b = '0;
			end else begin
				a = '0;
				b = '0;
			end
		end
	endtask

	task automatic driveProducer();
		logic [GCD_W-1:0] a;
		logic [GCD_W-1:0] b;
		logic [31:0] r;
		int credits;
		credits = QUEUE_DEPTH - sent + creditPulses;
		r = nextRandom();
		if (sent < NUM_JOBS && credits > 0 && r[0]) begin
			makeOperands(a, b);
			reqValid <= 1'b1;
			reqA <= a;
			reqB <= b;
			reqTag <= nextTag;
			expGcd.push_back(modelGcd(a, b));
			expTag.push_back(nextTag);
			nextTag = nextTag + 1'b1;
			sent++;
		end else begin
			reqValid <= 1'b0;
		end
	endtask

	// Consumer frees a slot for every result it has taken
	task automatic driveConsumer();
		logic [31:0] r;
		r = nextRandom();
		if (!holdDone && holdLeft == 0 && sent >= HOLD_AT_JOB) begin
			holdLeft = HOLD_CYCLES;
		end
		if (holdLeft > 0) begin
			holdLeft--;
			if (holdLeft == 0) begin
				holdDone = 1'b1;
			end
			resCredit <= 1'b0;
		end else if (received > granted && r[1]) begin
			resCredit <= 1'b1;
			granted++;
		end else begin
			resCredit <= 1'b0;
		end
	endtask

	// Outputs sampled on the falling edge
	always @(negedge clk) begin
		if (reset) begin
			checkValue("reqCredit", 32'd0, 32'(reqCredit));
			checkValue("resValid", 32'd0, 32'(resValid));
		end else begin
			if (!firstCycleSeen) begin
				checkValue("reqCredit", 32'd0, 32'(reqCredit));
				checkValue("resValid", 32'd0, 32'(resValid));
				firstCycleSeen = 1'b1;
			end
			if (reqCredit) begin
				creditPulses++;
				if (creditPulses > sent) begin
					$display("More reqCredit pulses (%0d) than jobs sent (%0d)", creditPulses, sent);
					stopOnFailure();
				end
			end
			if (resValid) begin
				received++;
				if (expGcd.size() == 0) begin
					$display("resValid at %0t with no job outstanding", $time);
					stopOnFailure();
				end
				if (received > RES_CREDITS + granted) begin
					$display("resValid at %0t without a result credit", $time);
					stopOnFailure();
				end
				checkValue("resGcd", expGcd.pop_front(), resGcd);
				checkValue("resTag", 32'(expTag.pop_front()), 32'(resTag));
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with %0d of %0d results seen",
			WATCHDOG_NS, received, NUM_JOBS);
		stopOnFailure();
	end

	initial begin
		reset = 1'b1;
		reqValid = 1'b0;
		reqA = '0;
		reqB = '0;
		reqTag = '0;
		resCredit = 1'b0;
		nextTag = '0;
		sent = 0;
		received = 0;
		creditPulses = 0;
		granted = 0;
		holdLeft = 0;
		holdDone = 1'b0;
		firstCycleSeen = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		while (received < NUM_JOBS) begin
			@(posedge clk);
			driveProducer();
			driveConsumer();
		end
		@(posedge clk);
		reqValid <= 1'b0;
		resCredit <= 1'b0;
		repeat (4) @(posedge clk);

		checkValue("reqCredit pulses", sent, creditPulses);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
